/* hdl/send_recv_engine.sv */
module send_recv_engine (
  input  logic                                aclk,
  input  logic                                aresetn,
  input  logic                                ap_start,
  output logic                                ap_done,
  input  sr_pkg::bench_cfg_t                  cfg,
  output sr_pkg::bench_stat_t                 stat,
  input  logic                                link_up,
  output logic                                tx_valid,
  output logic [sr_pkg::STREAM_DATA_BITS-1:0] tx_data,
  output logic                                tx_last,
  input  logic                                rx_valid,
  input  logic [sr_pkg::STREAM_DATA_BITS-1:0] rx_data
);

  // ----------------------------------------------------------
  // declarations
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_OPEN,   // waiting for the link
    ST_RUN
  } state_t;

  state_t                      state;
  logic [sr_pkg::CFG_BITS-1:0] word_cnt;   // words sent so far, also the payload
  logic [sr_pkg::CFG_BITS-1:0] pkt_cnt;    // position inside the packet
  logic [sr_pkg::CFG_BITS-1:0] n_words;

  logic client;
  logic all_sent;
  logic last_word;
  logic pkt_end;
  logic time_hit;
  logic rx_done;
  logic end_now;

  // ----------------------------------------------------------
  // run decode
  // ----------------------------------------------------------
  assign client  = (cfg.is_server == '0);
  assign n_words = cfg.transfer_size >> sr_pkg::STREAM_BYTES_LOG2;

  assign all_sent  = (word_cnt >= n_words);
  assign last_word = (word_cnt == n_words - 1'b1);
  // pkg_word_count of 0 gives a single packet
  assign pkt_end   = (cfg.pkg_word_count != '0) &&
                     (pkt_cnt == cfg.pkg_word_count - 1'b1);

  assign time_hit = (cfg.time_in_cycles != '0) &&
                    (stat.execution_cycles == cfg.time_in_cycles);
  assign rx_done  = stat.consumed_bytes >=
                    {{(sr_pkg::STAT_BITS-sr_pkg::CFG_BITS){1'b0}}, cfg.transfer_size};
  assign end_now  = time_hit || rx_done;

  // ----------------------------------------------------------
  // state machine and statistics
  // ----------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state    <= ST_IDLE;
      ap_done  <= 1'b0;
      tx_valid <= 1'b0;
      tx_last  <= 1'b0;
      word_cnt <= '0;
      pkt_cnt  <= '0;
      stat     <= '0;
    end else begin
      tx_valid <= 1'b0;
      tx_last  <= 1'b0;

      if (tx_valid) begin
        stat.produced_bytes <= stat.produced_bytes + sr_pkg::STAT_BYTE_STEP;
      end

      case (state)
        ST_IDLE: begin
          if (ap_start) begin
            state    <= ST_OPEN;
            ap_done  <= 1'b0;
            word_cnt <= '0;
            pkt_cnt  <= '0;
            stat     <= '0;   // fresh counters per run
          end
        end

        ST_OPEN: begin
          if (link_up) begin
            state <= ST_RUN;
          end else begin
            stat.open_con_cycles <= stat.open_con_cycles + 1'b1;
          end
        end

        ST_RUN: begin
          if (end_now) begin
            state   <= ST_IDLE;
            ap_done <= 1'b1;
          end else begin
            stat.execution_cycles <= stat.execution_cycles + 1'b1;
            if (rx_valid) begin
              stat.consumed_bytes <= stat.consumed_bytes + sr_pkg::STAT_BYTE_STEP;
            end

            if (client) begin
              // one generated word per cycle until transfer_size is covered
              if (!all_sent) begin
                tx_valid <= 1'b1;
                tx_last  <= last_word || pkt_end;
                word_cnt <= word_cnt + 1'b1;
                pkt_cnt  <= pkt_end ? '0 : pkt_cnt + 1'b1;
              end
            end else begin
              tx_valid <= rx_valid;  // echo, tx_last stays low
            end
          end
        end

        default: state <= ST_IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------
  // tx payload
  // ----------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (client) begin
      tx_data <= {{(sr_pkg::STREAM_DATA_BITS-sr_pkg::CFG_BITS){1'b0}}, word_cnt};
    end else begin
      tx_data <= rx_data;  // one cycle echo
    end
  end

endmodule

/* hdl/send_recv_slave.sv */
module send_recv_slave (
  input  logic                aclk,
  input  logic                aresetn,
  input  sr_pkg::axil_m2s_t   axil_req,
  output sr_pkg::axil_s2m_t   axil_rsp,
  output logic                ap_start,
  input  logic                ap_done,
  output sr_pkg::bench_cfg_t  cfg,
  output sr_pkg::bench_net_t  net,
  input  sr_pkg::bench_stat_t stat
);

  /* register map
     0  (wo) control, bit 0 starts a run
     1  (ro) status, bit 0 done
     2  to 10 (rw) configuration
     11 to 14 (ro) statistics, low 32 bits
  */

  // ----------------------------------------------------------
  // declarations
  // ----------------------------------------------------------
  logic [sr_pkg::REG_IDX_BITS-1:0] wr_idx;
  logic [sr_pkg::REG_IDX_BITS-1:0] rd_idx;
  logic                            wr_en;
  logic                            rd_en;

  logic                            aw_en;       // no write outstanding
  logic                            wr_ready_q;  // awready and wready together
  logic                            bvalid_q;
  logic                            arready_q;
  logic                            rvalid_q;
  logic [sr_pkg::AXIL_DATA_BITS-1:0] rdata_q;
  logic [sr_pkg::AXIL_DATA_BITS-1:0] rd_word;
  logic                            start_q;

  // configuration slots 2 to 10
  logic [sr_pkg::REG_TIME_CYC:sr_pkg::REG_USE_CONN][sr_pkg::AXIL_DATA_BITS-1:0] cfg_regs;

  // addresses are stable while valid is high, so decode straight from the bus
  assign wr_idx = axil_req.awaddr[sr_pkg::AXIL_ADDR_BITS-1:sr_pkg::AXIL_ADDR_LSB];
  assign rd_idx = axil_req.araddr[sr_pkg::AXIL_ADDR_BITS-1:sr_pkg::AXIL_ADDR_LSB];

  assign wr_en = wr_ready_q & axil_req.awvalid & axil_req.wvalid;
  assign rd_en = arready_q & axil_req.arvalid & ~rvalid_q;

  // ----------------------------------------------------------
  // write channel
  // ----------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ready_q <= 1'b0;
      aw_en      <= 1'b1;
    end else begin
      if (!wr_ready_q && axil_req.awvalid && axil_req.wvalid && aw_en) begin
        wr_ready_q <= 1'b1;  // one cycle pulse
        aw_en      <= 1'b0;
      end else begin
        wr_ready_q <= 1'b0;
        if (bvalid_q && axil_req.bready) begin
          aw_en <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      bvalid_q <= 1'b0;
    end else if (wr_en) begin
      bvalid_q <= 1'b1;
    end else if (bvalid_q && axil_req.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  // byte enabled config registers, other slots drop the data
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      cfg_regs <= '0;
    end else if (wr_en) begin
      case (wr_idx)
        sr_pkg::REG_USE_CONN, sr_pkg::REG_USE_IP, sr_pkg::REG_PKG_WORDS,
        sr_pkg::REG_BASE_PORT, sr_pkg::REG_BASE_IP, sr_pkg::REG_XFER_SIZE,
        sr_pkg::REG_IS_SERVER, sr_pkg::REG_TIME_SEC, sr_pkg::REG_TIME_CYC: begin
          for (int b = 0; b < sr_pkg::AXIL_STRB_BITS; b++) begin
            if (axil_req.wstrb[b]) begin
              cfg_regs[wr_idx][8*b +: 8] <= axil_req.wdata[8*b +: 8];
            end
          end
        end
        default: ;
      endcase
    end
  end

  // start pulse, clears itself the next cycle
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      start_q <= 1'b0;
    end else begin
      start_q <= wr_en && (wr_idx == sr_pkg::REG_CTRL) &&
                 axil_req.wstrb[0] && axil_req.wdata[0];
    end
  end

  // ----------------------------------------------------------
  // read channel
  // ----------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      arready_q <= 1'b0;
    end else begin
      arready_q <= !arready_q && axil_req.arvalid && !rvalid_q;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rvalid_q <= 1'b0;
    end else if (rd_en) begin
      rvalid_q <= 1'b1;
    end else if (rvalid_q && axil_req.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_comb begin
    rd_word = '0;  // control and unused slots
    case (rd_idx)
      sr_pkg::REG_STATUS: rd_word[0] = ap_done;
      sr_pkg::REG_USE_CONN, sr_pkg::REG_USE_IP, sr_pkg::REG_PKG_WORDS,
      sr_pkg::REG_BASE_PORT, sr_pkg::REG_BASE_IP, sr_pkg::REG_XFER_SIZE,
      sr_pkg::REG_IS_SERVER, sr_pkg::REG_TIME_SEC, sr_pkg::REG_TIME_CYC: begin
        rd_word = cfg_regs[rd_idx];
      end
      sr_pkg::REG_EXEC_CYC:   rd_word = stat.execution_cycles[sr_pkg::AXIL_DATA_BITS-1:0];
      sr_pkg::REG_CONS_BYTES: rd_word = stat.consumed_bytes[sr_pkg::AXIL_DATA_BITS-1:0];
      sr_pkg::REG_PROD_BYTES: rd_word = stat.produced_bytes[sr_pkg::AXIL_DATA_BITS-1:0];
      sr_pkg::REG_OPEN_CYC:   rd_word = stat.open_con_cycles[sr_pkg::AXIL_DATA_BITS-1:0];
      default: ;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (rd_en) begin
      rdata_q <= rd_word;  // held until rready
    end
  end

  // ----------------------------------------------------------
  // outputs
  // ----------------------------------------------------------
  always_comb begin
    axil_rsp.awready = wr_ready_q;
    axil_rsp.wready  = wr_ready_q;
    axil_rsp.bresp   = sr_pkg::AXI_RESP_OKAY;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.arready = arready_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = sr_pkg::AXI_RESP_OKAY;
    axil_rsp.rvalid  = rvalid_q;
  end

  assign ap_start = start_q;

  always_comb begin
    cfg.pkg_word_count = cfg_regs[sr_pkg::REG_PKG_WORDS];
    cfg.transfer_size  = cfg_regs[sr_pkg::REG_XFER_SIZE];
    cfg.is_server      = cfg_regs[sr_pkg::REG_IS_SERVER];
    // only 32 bits of the cycle limit are writable
    cfg.time_in_cycles = {{(sr_pkg::STAT_BITS-sr_pkg::AXIL_DATA_BITS){1'b0}},
                          cfg_regs[sr_pkg::REG_TIME_CYC]};
  end

  always_comb begin
    net.use_conn        = cfg_regs[sr_pkg::REG_USE_CONN];
    net.use_ip_addr     = cfg_regs[sr_pkg::REG_USE_IP];
    net.base_port       = cfg_regs[sr_pkg::REG_BASE_PORT];
    net.base_ip_addr    = cfg_regs[sr_pkg::REG_BASE_IP];
    net.time_in_seconds = cfg_regs[sr_pkg::REG_TIME_SEC];
  end

endmodule

/* hdl/send_recv_top.sv */
module send_recv_top (
  input  logic                                aclk,
  input  logic                                aresetn,
  input  sr_pkg::axil_m2s_t                   axil_req,
  output sr_pkg::axil_s2m_t                   axil_rsp,
  output sr_pkg::bench_net_t                  net,
  input  logic                                link_up,
  output logic                                tx_valid,
  output logic [sr_pkg::STREAM_DATA_BITS-1:0] tx_data,
  output logic                                tx_last,
  input  logic                                rx_valid,
  input  logic [sr_pkg::STREAM_DATA_BITS-1:0] rx_data
);

  // ----------------------------------------------------------
  // slave to engine
  // ----------------------------------------------------------
  logic                ap_start;
  logic                ap_done;
  sr_pkg::bench_cfg_t  cfg;
  sr_pkg::bench_stat_t stat;

  send_recv_slave slave_i (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .ap_start (ap_start),
    .ap_done  (ap_done),
    .cfg      (cfg),
    .net      (net),        // out to the network stack
    .stat     (stat)
  );

  send_recv_engine engine_i (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .ap_start (ap_start),
    .ap_done  (ap_done),
    .cfg      (cfg),
    .stat     (stat),
    .link_up  (link_up),
    .tx_valid (tx_valid),
    .tx_data  (tx_data),
    .tx_last  (tx_last),
    .rx_valid (rx_valid),
    .rx_data  (rx_data)
  );

endmodule

/* hdl/sr_pkg.sv */
package sr_pkg;

  // ----------------------------------------------------------
  // bus geometry
  // ----------------------------------------------------------
  localparam int AXIL_DATA_BITS = 32;
  localparam int AXIL_ADDR_BITS = 6;                        // 16 word slots
  localparam int AXIL_STRB_BITS = AXIL_DATA_BITS / 8;
  localparam int AXIL_ADDR_LSB  = $clog2(AXIL_STRB_BITS);
  localparam int REG_IDX_BITS   = AXIL_ADDR_BITS - AXIL_ADDR_LSB;
  localparam int N_REGS         = 15;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // register map, word indexes
  localparam logic [REG_IDX_BITS-1:0] REG_CTRL       = 4'd0;  // write only
  localparam logic [REG_IDX_BITS-1:0] REG_STATUS     = 4'd1;  // read only
  localparam logic [REG_IDX_BITS-1:0] REG_USE_CONN   = 4'd2;
  localparam logic [REG_IDX_BITS-1:0] REG_USE_IP     = 4'd3;
  localparam logic [REG_IDX_BITS-1:0] REG_PKG_WORDS  = 4'd4;
  localparam logic [REG_IDX_BITS-1:0] REG_BASE_PORT  = 4'd5;
  localparam logic [REG_IDX_BITS-1:0] REG_BASE_IP    = 4'd6;
  localparam logic [REG_IDX_BITS-1:0] REG_XFER_SIZE  = 4'd7;
  localparam logic [REG_IDX_BITS-1:0] REG_IS_SERVER  = 4'd8;
  localparam logic [REG_IDX_BITS-1:0] REG_TIME_SEC   = 4'd9;
  localparam logic [REG_IDX_BITS-1:0] REG_TIME_CYC   = 4'd10;
  localparam logic [REG_IDX_BITS-1:0] REG_EXEC_CYC   = 4'd11; // stats, low word only
  localparam logic [REG_IDX_BITS-1:0] REG_CONS_BYTES = 4'd12;
  localparam logic [REG_IDX_BITS-1:0] REG_PROD_BYTES = 4'd13;
  localparam logic [REG_IDX_BITS-1:0] REG_OPEN_CYC   = 4'd14;

  // ----------------------------------------------------------
  // data side
  // ----------------------------------------------------------
  localparam int STREAM_DATA_BITS  = 64;
  localparam int STREAM_BYTES      = STREAM_DATA_BITS / 8;
  localparam int STREAM_BYTES_LOG2 = $clog2(STREAM_BYTES);
  localparam int CFG_BITS          = 32;
  localparam int STAT_BITS         = 64;

  localparam logic [STAT_BITS-1:0] STAT_BYTE_STEP = STREAM_BYTES;

  // ----------------------------------------------------------
  // structs
  // ----------------------------------------------------------
  typedef struct packed {
    logic [AXIL_ADDR_BITS-1:0] awaddr;
    logic                      awvalid;
    logic [AXIL_DATA_BITS-1:0] wdata;
    logic [AXIL_STRB_BITS-1:0] wstrb;
    logic                      wvalid;
    logic                      bready;
    logic [AXIL_ADDR_BITS-1:0] araddr;
    logic                      arvalid;
    logic                      rready;
  } axil_m2s_t;

  typedef struct packed {
    logic                      awready;
    logic                      wready;
    logic [1:0]                bresp;
    logic                      bvalid;
    logic                      arready;
    logic [AXIL_DATA_BITS-1:0] rdata;
    logic [1:0]                rresp;
    logic                      rvalid;
  } axil_s2m_t;

  typedef struct packed {
    logic [CFG_BITS-1:0]  pkg_word_count;
    logic [CFG_BITS-1:0]  transfer_size;   // bytes
    logic [CFG_BITS-1:0]  is_server;
    logic [STAT_BITS-1:0] time_in_cycles;  // 0 means no limit
  } bench_cfg_t;

  // only stored here, consumed by the network stack
  typedef struct packed {
    logic [CFG_BITS-1:0] use_conn;
    logic [CFG_BITS-1:0] use_ip_addr;
    logic [CFG_BITS-1:0] base_port;
    logic [CFG_BITS-1:0] base_ip_addr;
    logic [CFG_BITS-1:0] time_in_seconds;
  } bench_net_t;

  typedef struct packed {
    logic [STAT_BITS-1:0] execution_cycles;
    logic [STAT_BITS-1:0] consumed_bytes;
    logic [STAT_BITS-1:0] produced_bytes;
    logic [STAT_BITS-1:0] open_con_cycles;
  } bench_stat_t;

endpackage

/* list.f */
hdl/sr_pkg.sv
hdl/send_recv_slave.sv
hdl/send_recv_engine.sv
hdl/send_recv_top.sv
sim/send_recv_properties.sv
sim/send_recv_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module send_recv_tb \
  -f list.f -o send_recv_sim

out=$(./obj_dir/send_recv_sim +verilator+error+limit+100 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
echo "simulation did not pass"
exit 1

/* sim/send_recv_properties.sv */
module send_recv_properties (
  input logic              aclk,
  input logic              aresetn,
  input sr_pkg::axil_m2s_t axil_req,
  input sr_pkg::axil_s2m_t axil_rsp,
  input logic              ap_start,
  input logic              ap_done,
  input logic              tx_valid,
  input logic              tx_last
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;  // summed into the closing line

  // ------------------------------------------------------------
  // bus responses hold until taken
  // ------------------------------------------------------------
  bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else begin
      $error("bvalid dropped before bready");
      fail_cnt++;
    end

  rvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
    else begin
      $error("rvalid dropped before rready");
      fail_cnt++;
    end

  // ------------------------------------------------------------
  // run control and stream
  // ------------------------------------------------------------
  start_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
    ap_start |=> !ap_start)
    else begin
      $error("ap_start high for more than one cycle");
      fail_cnt++;
    end

  tx_after_done: assert property (@(posedge aclk) disable iff (!aresetn)
    tx_valid |-> !ap_done)
    else begin
      $error("tx_valid high while ap_done is set");
      fail_cnt++;
    end

  last_needs_valid: assert property (@(posedge aclk) disable iff (!aresetn)
    tx_last |-> tx_valid)
    else begin
      $error("tx_last high without tx_valid");
      fail_cnt++;
    end

endmodule

bind send_recv_top send_recv_properties props_i (
  .aclk     (aclk),
  .aresetn  (aresetn),
  .axil_req (axil_req),
  .axil_rsp (axil_rsp),
  .ap_start (ap_start),
  .ap_done  (ap_done),
  .tx_valid (tx_valid),
  .tx_last  (tx_last)
);

/* sim/send_recv_tb.sv */
module send_recv_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 4000;  // twice the summed run lengths

  logic                aclk;
  logic                aresetn;
  sr_pkg::axil_m2s_t   axil_req;
  sr_pkg::axil_s2m_t   axil_rsp;
  sr_pkg::bench_net_t  net;
  logic                link_up;
  logic                tx_valid;
  logic [63:0]         tx_data;
  logic                tx_last;
  logic                rx_valid;
  logic [63:0]         rx_data;
  logic                rx_valid_drv;
  logic [63:0]         rx_data_drv;
  logic                loopback;   // tx straight back into rx

  int          errors = 0;
  int          seed = 2;
  logic [63:0] tx_words[$];
  logic        tx_lasts[$];
  logic        echo_chk;
  logic        prev_rx_valid;
  logic [63:0] prev_rx_data;

  assign rx_valid = loopback ? tx_valid : rx_valid_drv;
  assign rx_data  = loopback ? tx_data : rx_data_drv;

  send_recv_top dut_i (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .net      (net),
    .link_up  (link_up),
    .tx_valid (tx_valid),
    .tx_data  (tx_data),
    .tx_last  (tx_last),
    .rx_valid (rx_valid),
    .rx_data  (rx_data)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge aclk);
      cycles++;
    end
    $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  // ------------------------------------------------------------
  // checks and bus tasks
  // ------------------------------------------------------------
  task automatic check_range(input string name, input logic [63:0] lo,
                             input logic [63:0] hi, input logic [63:0] act);
    assert (act >= lo && act <= hi) else begin
      errors++;
      if (lo == hi)
        $display("FAIL %s: expected %0h, actual %0h", name, lo, act);
      else
        $display("FAIL %s: expected %0h..%0h, actual %0h", name, lo, hi, act);
    end
  endtask

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    check_range(name, exp, exp, act);
  endtask

  task automatic next_cycle();
    @(posedge aclk);
    #1;
  endtask

  task automatic bus_write(input logic [3:0] idx, input logic [31:0] data,
                           input logic [3:0] strb);
    next_cycle();
    axil_req.awaddr  = {idx, 2'b00};
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = strb;
    axil_req.wvalid  = 1'b1;
    axil_req.bready  = 1'b1;
    do next_cycle(); while (!axil_rsp.awready);
    check_eq("wready with awready", 1'b1, axil_rsp.wready);
    next_cycle();  // handshake edge just passed
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    while (!axil_rsp.bvalid) next_cycle();
    check_eq("bresp okay", 2'b00, axil_rsp.bresp);
    next_cycle();
    axil_req.bready = 1'b0;
  endtask

  task automatic bus_read(input logic [3:0] idx, output logic [31:0] data);
    next_cycle();
    axil_req.araddr  = {idx, 2'b00};
    axil_req.arvalid = 1'b1;
    axil_req.rready  = 1'b1;
    do next_cycle(); while (!axil_rsp.arready);
    next_cycle();
    axil_req.arvalid = 1'b0;
    while (!axil_rsp.rvalid) next_cycle();
    data = axil_rsp.rdata;
    check_eq("rresp okay", 2'b00, axil_rsp.rresp);
    next_cycle();
    axil_req.rready = 1'b0;
  endtask

  task automatic read_expect(input string name, input logic [3:0] idx, input logic [31:0] exp);
    logic [31:0] v;
    bus_read(idx, v);
    check_eq(name, exp, v);
  endtask

  task automatic wait_done();
    logic [31:0] v;
    do bus_read(sr_pkg::REG_STATUS, v); while (!v[0]);
  endtask

  // tx capture and echo compare against last cycle's rx
  always @(negedge aclk) begin
    if (tx_valid) begin
      tx_words.push_back(tx_data);
      tx_lasts.push_back(tx_last);
    end
    if (echo_chk) begin
      check_eq("echo valid", prev_rx_valid, tx_valid);
      check_eq("echo last", 1'b0, tx_last);
      if (prev_rx_valid)
        check_eq("echo data", prev_rx_data, tx_data);
    end
    prev_rx_valid = rx_valid;
    prev_rx_data  = rx_data;
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  initial begin : stimulus
    logic [31:0] v;
    int          n_echo;
    axil_req      = '0;
    aresetn       = 1'b0;
    link_up       = 1'b0;
    loopback      = 1'b0;
    rx_valid_drv  = 1'b0;
    rx_data_drv   = '0;
    echo_chk      = 1'b0;
    prev_rx_valid = 1'b0;
    prev_rx_data  = '0;
    repeat (5) @(posedge aclk);
    #1;
    aresetn = 1'b1;

    // reset values, readback, byte strobes, read only slot
    for (int i = 0; i < 16; i++)
      read_expect($sformatf("reset slot %0d", i), 4'(i), 32'h0);
    for (int i = 2; i <= 10; i++)
      bus_write(4'(i), 32'h0101_0101 * i, 4'hf);
    for (int i = 2; i <= 10; i++)
      read_expect($sformatf("readback slot %0d", i), 4'(i), 32'h0101_0101 * i);
    bus_write(sr_pkg::REG_BASE_PORT, 32'hffff_ffff, 4'b0101);
    read_expect("partial strobe", sr_pkg::REG_BASE_PORT, 32'h05ff_05ff);
    check_eq("net use_conn", 32'h0202_0202, net.use_conn);
    check_eq("net use_ip_addr", 32'h0303_0303, net.use_ip_addr);
    check_eq("net base_port", 32'h05ff_05ff, net.base_port);
    check_eq("net base_ip_addr", 32'h0606_0606, net.base_ip_addr);
    check_eq("net time_in_seconds", 32'h0909_0909, net.time_in_seconds);
    bus_write(sr_pkg::REG_CONS_BYTES, 32'hdead_beef, 4'hf);
    read_expect("stat slot write", sr_pkg::REG_CONS_BYTES, 32'h0);

    // client loopback of 32 words in packets of 8
    bus_write(sr_pkg::REG_PKG_WORDS, 32'd8, 4'hf);
    bus_write(sr_pkg::REG_XFER_SIZE, 32'd256, 4'hf);
    bus_write(sr_pkg::REG_IS_SERVER, 32'd0, 4'hf);
    bus_write(sr_pkg::REG_TIME_CYC, 32'd0, 4'hf);
    read_expect("status before run", sr_pkg::REG_STATUS, 32'h0);
    link_up  = 1'b1;
    loopback = 1'b1;
    tx_words.delete();
    tx_lasts.delete();
    bus_write(sr_pkg::REG_CTRL, 32'h1, 4'hf);
    read_expect("control reads 0", sr_pkg::REG_CTRL, 32'h0);
    wait_done();
    check_eq("client word count", 32, tx_words.size());
    for (int i = 0; i < tx_words.size(); i++) begin
      check_eq($sformatf("client data %0d", i), i, tx_words[i]);
      check_eq($sformatf("client last %0d", i), (i % 8 == 7) || (i == 31), tx_lasts[i]);
    end
    read_expect("status after done", sr_pkg::REG_STATUS, 32'h1);
    read_expect("client consumed", sr_pkg::REG_CONS_BYTES, 32'd256);
    read_expect("client produced", sr_pkg::REG_PROD_BYTES, 32'd256);
    bus_read(sr_pkg::REG_EXEC_CYC, v);
    check_range("client execution_cycles", 32, 64'hffff_ffff, v);

    // server echo of 8 random words with random gaps
    loopback = 1'b0;
    bus_write(sr_pkg::REG_XFER_SIZE, 32'd64, 4'hf);
    bus_write(sr_pkg::REG_IS_SERVER, 32'd1, 4'hf);
    bus_write(sr_pkg::REG_CTRL, 32'h1, 4'hf);
    next_cycle();
    next_cycle();  // engine is in the run state by now
    echo_chk = 1'b1;
    n_echo   = 0;
    while (n_echo < 8) begin
      rx_valid_drv = 1'($random(seed));
      rx_data_drv  = {$random(seed), $random(seed)};
      if (rx_valid_drv)
        n_echo++;
      next_cycle();
    end
    rx_valid_drv = 1'b0;
    wait_done();
    echo_chk = 1'b0;
    read_expect("echo consumed", sr_pkg::REG_CONS_BYTES, 32'd64);
    read_expect("echo produced", sr_pkg::REG_PROD_BYTES, 32'd64);

    // time limit stops a long client run with nothing coming back
    bus_write(sr_pkg::REG_IS_SERVER, 32'd0, 4'hf);
    bus_write(sr_pkg::REG_XFER_SIZE, 32'h0001_0000, 4'hf);
    bus_write(sr_pkg::REG_TIME_CYC, 32'd10, 4'hf);
    bus_write(sr_pkg::REG_CTRL, 32'h1, 4'hf);
    wait_done();
    read_expect("limit execution_cycles", sr_pkg::REG_EXEC_CYC, 32'd10);
    read_expect("limit produced", sr_pkg::REG_PROD_BYTES, 32'd80);

    // link comes up 20 cycles after start
    bus_write(sr_pkg::REG_XFER_SIZE, 32'd64, 4'hf);
    bus_write(sr_pkg::REG_TIME_CYC, 32'd0, 4'hf);
    link_up  = 1'b0;
    loopback = 1'b1;
    bus_write(sr_pkg::REG_CTRL, 32'h1, 4'hf);
    repeat (20) next_cycle();
    link_up = 1'b1;
    wait_done();
    bus_read(sr_pkg::REG_OPEN_CYC, v);
    check_range("open_con_cycles", 20, 22, v);

    $display("errors: %0d value checks, %0d assertion failures",
             errors, dut_i.props_i.fail_cnt);
    if (errors == 0 && dut_i.props_i.fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
